//--- filelist.f
+incdir+.
rob_pkg.sv
rob_ptrs.sv
rob_entry_store.sv
rob_commit.sv
rob_top.sv
tb_rob.sv

//--- Bender.yml
package:
  name: rob

sources:
  - include_dirs:
      - .
    files:
      - rob_pkg.sv
      - rob_ptrs.sv
      - rob_entry_store.sv
      - rob_commit.sv
      - rob_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rob.sv

//--- tb_rob.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_settings.svh"

module tb_rob;

    localparam int MAX_ROWS = 64;

    // one table row: a dispatch plus completions named by dispatch row
    typedef struct packed {
        logic                           disp_v;
        rob_pkg::rv_opcode_e            op;
        logic [`AREG_W-1:0]             areg;
        logic                           regf_we;
        logic [`ROB_CDB_PORTS-1:0]      c_v;
        logic [`ROB_CDB_PORTS-1:0]      c_taken;
        logic [`ROB_CDB_PORTS-1:0][7:0] c_seq;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  dispatch_valid;
    rob_pkg::dispatch_t    dispatch;
    rob_pkg::cdb_t         cdb [`ROB_CDB_PORTS];
    logic [`ROB_IDX_W-1:0] dispatch_idx;
    logic                  full;
    logic                  empty;
    logic                  commit_valid;
    rob_pkg::commit_t      commit;
    logic                  redirect_valid;
    logic [`XLEN-1:0]      redirect_pc;

    row_t  rows [MAX_ROWS];
    string row_name [MAX_ROWS];
    int    n_rows;

    // reference model, indexed by dispatch row
    logic                  m_live [MAX_ROWS];
    logic                  m_done [MAX_ROWS];
    logic                  m_taken [MAX_ROWS];
    logic [`ROB_IDX_W-1:0] m_idx [MAX_ROWS];
    logic [`XLEN-1:0]      m_result [MAX_ROWS];
    logic [`XLEN-1:0]      m_target [MAX_ROWS];
    int                    rob_q [$];
    int                    m_head;
    int                    m_tail;
    logic [`ORDER_W-1:0]   exp_order;
    logic                  pend_v [`ROB_CDB_PORTS];
    int                    pend_seq [`ROB_CDB_PORTS];

    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;

    rob_top uut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .dispatch_idx   (dispatch_idx),
        .full           (full),
        .empty          (empty),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic logic [`XLEN-1:0] pc_of(input int seq);
        return 32'h0000_1000 + 32'(seq * 4);
    endfunction

    task automatic add_row(input string name, input logic dv, input rob_pkg::rv_opcode_e op,
                           input int areg, input logic we);
        row_t r;
        r = '0;
        r.disp_v = dv;
        r.op = op;
        r.areg = `AREG_W'(areg);
        r.regf_we = we;
        rows[n_rows] = r;
        row_name[n_rows] = name;
        n_rows++;
    endtask

    // completion on a port for the instruction dispatched in row seq
    task automatic add_cpl(input int port, input int seq, input logic taken);
        row_t r;
        r = rows[n_rows-1];
        r.c_v[port] = 1'b1;
        r.c_taken[port] = taken;
        r.c_seq[port] = 8'(seq);
        rows[n_rows-1] = r;
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input logic [`ROB_IDX_W-1:0] exp,
                             input logic [`ROB_IDX_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s dispatch_idx: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s redirect_pc: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_commit(input string name, input rob_pkg::commit_t exp,
                                input rob_pkg::commit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s commit: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic drive_idle();
        dispatch_valid = 1'b0;
        for (int p = 0; p < `ROB_CDB_PORTS; p++) begin
            cdb[p] = '0;
            pend_v[p] = 1'b0;
        end
    endtask

    task automatic apply_row(input int r);
        row_t row;
        int   s;
        row = rows[r];
        dispatch_valid = row.disp_v;
        dispatch.preg = `PREG_W'(r);
        dispatch.areg = row.areg;
        dispatch.pc = pc_of(r);
        dispatch.opcode = row.op;
        dispatch.regf_we = row.regf_we;
        for (int p = 0; p < `ROB_CDB_PORTS; p++) begin
            cdb[p] = '0;
            pend_v[p] = 1'b0;
            s = int'(row.c_seq[p]);
            // only instructions still in flight get a completion
            if (row.c_v[p] && m_live[s] && !m_done[s]) begin
                m_result[s] = draw_bits(32);
                m_target[s] = {draw_bits(30), 2'b00};
                m_taken[s] = row.c_taken[p];
                cdb[p].valid = 1'b1;
                cdb[p].idx = m_idx[s];
                cdb[p].result = m_result[s];
                cdb[p].br_taken = m_taken[s];
                cdb[p].br_target = m_target[s];
                pend_v[p] = 1'b1;
                pend_seq[p] = s;
            end
        end
    endtask

    // compare outputs, then advance the model across the coming edge
    task automatic check_cycle(input string name, input logic dv, input int seq);
        rob_pkg::commit_t exp_c;
        logic             exp_commit;
        logic             exp_flush;
        logic             was_full;
        int               s;
        exp_flush = 1'b0;
        was_full = (rob_q.size() == `ROB_DEPTH);
        exp_commit = (rob_q.size() > 0) && m_done[rob_q[0]];
        check_flag(name, "empty", rob_q.size() == 0, empty);
        check_flag(name, "full", was_full, full);
        check_idx(name, `ROB_IDX_W'(m_tail), dispatch_idx);
        check_flag(name, "commit_valid", exp_commit, commit_valid);
        if (exp_commit) begin
            s = rob_q[0];
            exp_c.order = exp_order;
            exp_c.preg = `PREG_W'(s);
            exp_c.pc = pc_of(s);
            exp_c.result = m_result[s];
            exp_c.regf_we = rows[s].regf_we;
            // stores and branches write no architectural register
            if (rows[s].op == rob_pkg::op_store || rows[s].op == rob_pkg::op_branch) begin
                exp_c.areg = '0;
            end else begin
                exp_c.areg = rows[s].areg;
            end
            check_commit(name, exp_c, commit);
            exp_flush = m_taken[s];
            if (exp_flush) begin
                check_pc(name, m_target[s], redirect_pc);
            end
            m_live[s] = 1'b0;
            void'(rob_q.pop_front());
            m_head = (m_head + 1) % `ROB_DEPTH;
            exp_order++;
        end
        check_flag(name, "redirect_valid", exp_flush, redirect_valid);
        // full is judged before this cycle's commit frees a slot
        if (exp_flush) begin
            foreach (rob_q[i]) begin
                m_live[rob_q[i]] = 1'b0;
            end
            rob_q.delete();
            m_tail = m_head;
        end else if (dv && !was_full) begin
            m_idx[seq] = `ROB_IDX_W'(m_tail);
            m_live[seq] = 1'b1;
            rob_q.push_back(seq);
            m_tail = (m_tail + 1) % `ROB_DEPTH;
        end
        for (int p = 0; p < `ROB_CDB_PORTS; p++) begin
            if (pend_v[p]) begin
                m_done[pend_seq[p]] = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > limit) begin
                $display("run stopped after %0d cycles without finishing", cycles);
                $display("errors: %0d of %0d checks", errors, checks);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dispatch = '0;
        drive_idle();
        lfsr_q = 16'd9022;
        errors = 0;
        checks = 0;
        cycles = 0;
        n_rows = 0;
        m_head = 0;
        m_tail = 0;
        exp_order = '0;
        for (int i = 0; i < MAX_ROWS; i++) begin
            m_live[i] = 1'b0;
            m_done[i] = 1'b0;
            m_taken[i] = 1'b0;
        end

        // out-of-order completion, several ports per cycle
        add_row("ooo_reg", 1, rob_pkg::op_reg, 1, 1);
        add_row("ooo_imm", 1, rob_pkg::op_imm, 2, 1);
        add_row("ooo_store", 1, rob_pkg::op_store, 3, 0);
        add_row("ooo_load", 1, rob_pkg::op_load, 4, 1);
        add_cpl(0, 2, 0);
        add_cpl(1, 1, 0);
        add_row("ooo_branch", 1, rob_pkg::op_branch, 5, 0);
        add_cpl(0, 3, 0);
        add_cpl(1, 0, 0);
        // branch not taken
        add_row("ooo_lui", 1, rob_pkg::op_lui, 6, 1);
        add_cpl(2, 4, 0);
        add_row("ooo_jal", 1, rob_pkg::op_jal, 7, 1);
        add_cpl(0, 5, 0);
        add_row("ooo_tail", 0, rob_pkg::op_reg, 0, 0);
        add_cpl(1, 6, 0);
        add_row("idle_a", 0, rob_pkg::op_reg, 0, 0);
        add_row("idle_b", 0, rob_pkg::op_reg, 0, 0);

        // taken branch with younger entries behind it
        add_row("br_taken", 1, rob_pkg::op_branch, 8, 0);
        add_row("br_young_a", 1, rob_pkg::op_reg, 9, 1);
        add_row("br_young_b", 1, rob_pkg::op_imm, 10, 1);
        add_cpl(0, 11, 0);
        add_cpl(2, 10, 1);
        add_row("br_redirect", 1, rob_pkg::op_reg, 11, 1);
        add_cpl(1, 12, 0);
        add_row("br_restart", 1, rob_pkg::op_auipc, 12, 1);
        add_row("restart_cpl", 0, rob_pkg::op_reg, 0, 0);
        add_cpl(0, 14, 0);
        add_row("restart_commit", 0, rob_pkg::op_reg, 0, 0);

        // fill the buffer, then push against full
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            add_row("fill", 1, (i % 2) ? rob_pkg::op_auipc : rob_pkg::op_reg, i + 1, 1);
        end
        add_row("full_refuse_a", 1, rob_pkg::op_reg, 20, 1);
        add_cpl(0, 17, 0);
        add_row("full_refuse_b", 1, rob_pkg::op_reg, 21, 1);
        add_row("full_falls", 1, rob_pkg::op_imm, 22, 1);
        for (int i = 0; i < 5; i++) begin
            if (i > 0) add_row("full_cpl", 0, rob_pkg::op_reg, 0, 0);
            add_cpl(0, 18 + 3 * i, 0);
            add_cpl(1, 19 + 3 * i, 0);
            add_cpl(2, 20 + 3 * i, 0);
        end
        // refused rows 33 and 34 must not complete
        add_row("full_cpl_last", 0, rob_pkg::op_reg, 0, 0);
        add_cpl(0, 35, 0);
        add_cpl(1, 33, 0);
        add_cpl(2, 34, 0);

        limit = n_rows + `ROB_DEPTH + 20;

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
            @(negedge clk);
            check_cycle(row_name[r], rows[r].disp_v, r);
            @(posedge clk);
            #2;
        end
        while (rob_q.size() > 0) begin
            drive_idle();
            @(negedge clk);
            check_cycle("drain", 1'b0, 0);
            @(posedge clk);
            #2;
        end

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rob_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_settings.svh"

module rob_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  rob_pkg::dispatch_t    dispatch,
    input  rob_pkg::cdb_t         cdb [`ROB_CDB_PORTS],
    output logic [`ROB_IDX_W-1:0] dispatch_idx,
    output logic                  full,
    output logic                  empty,
    output logic                  commit_valid,
    output rob_pkg::commit_t      commit,
    output logic                  redirect_valid,
    output logic [`XLEN-1:0]      redirect_pc
);

    logic                  enq_fire;
    logic                  commit_fire;
    logic                  flush;
    logic [`ROB_IDX_W-1:0] tail_idx;
    logic [`ROB_IDX_W-1:0] head_idx;
    rob_pkg::rob_entry_t   head_entry;

    // renamer tags with the slot the next dispatch lands in
    assign dispatch_idx = tail_idx;

    rob_ptrs u_ptrs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .commit_fire    (commit_fire),
        .flush          (flush),
        .enq_fire       (enq_fire),
        .tail_idx       (tail_idx),
        .head_idx       (head_idx),
        .full           (full),
        .empty          (empty)
    );

    rob_entry_store u_store (
        .clk         (clk),
        .rst         (rst),
        .enq_fire    (enq_fire),
        .tail_idx    (tail_idx),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .commit_fire (commit_fire),
        .flush       (flush),
        .head_idx    (head_idx),
        .head_entry  (head_entry)
    );

    rob_commit u_commit (
        .clk            (clk),
        .rst            (rst),
        .head_entry     (head_entry),
        .commit_fire    (commit_fire),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- rob_commit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_settings.svh"

module rob_commit (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::rob_entry_t head_entry,
    output logic                commit_fire,
    output logic                commit_valid,
    output rob_pkg::commit_t    commit,
    output logic                flush,
    output logic                redirect_valid,
    output logic [`XLEN-1:0]    redirect_pc
);

    logic [`ORDER_W-1:0] order_q;
    logic                no_rd;

    // head is ready once valid and written back
    assign commit_fire  = head_entry.valid && head_entry.done;
    assign commit_valid = commit_fire;

    // stores and branches have no architectural destination
    assign no_rd = (head_entry.ins.opcode == rob_pkg::op_store) ||
                   (head_entry.ins.opcode == rob_pkg::op_branch);

    always_comb begin
        commit.order   = order_q;
        commit.preg    = head_entry.ins.preg;
        commit.areg    = no_rd ? '0 : head_entry.ins.areg;
        commit.pc      = head_entry.ins.pc;
        commit.result  = head_entry.result;
        commit.regf_we = head_entry.ins.regf_we;
    end

    // redirect comes with the commit of a taken branch
    assign flush          = commit_fire && head_entry.br_taken;
    assign redirect_valid = flush;
    assign redirect_pc    = head_entry.br_target;

    // running retirement count
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (commit_fire) begin
            order_q <= order_q + 1'b1;
        end
    end

    // nothing younger than a taken branch may retire after it
    a_no_commit_after_flush: assert property (
        @(posedge clk) disable iff (rst)
        flush |=> !commit_fire
    );

endmodule

`default_nettype wire

//--- rob_entry_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_settings.svh"

module rob_entry_store (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enq_fire,
    input  logic [`ROB_IDX_W-1:0] tail_idx,
    input  rob_pkg::dispatch_t    dispatch,
    input  rob_pkg::cdb_t         cdb [`ROB_CDB_PORTS],
    input  logic                  commit_fire,
    input  logic                  flush,
    input  logic [`ROB_IDX_W-1:0] head_idx,
    output rob_pkg::rob_entry_t   head_entry
);

    rob_pkg::rob_entry_t mem [`ROB_DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            // only the valid bits matter after reset
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                mem[i].valid <= 1'b0;
            end
        end else begin
            // new instruction at the tail, whole entry rewritten
            if (enq_fire) begin
                mem[tail_idx] <= '{
                    valid:     1'b1,
                    done:      1'b0,
                    ins:       dispatch,
                    result:    '0,
                    br_taken:  1'b0,
                    br_target: '0
                };
            end

            // completions; a higher port wins on the same index
            for (int p = 0; p < `ROB_CDB_PORTS; p++) begin
                if (cdb[p].valid) begin
                    mem[cdb[p].idx].done      <= 1'b1;
                    mem[cdb[p].idx].result    <= cdb[p].result;
                    mem[cdb[p].idx].br_taken  <= cdb[p].br_taken;
                    mem[cdb[p].idx].br_target <= cdb[p].br_target;
                end
            end

            // retire the head
            if (commit_fire) begin
                mem[head_idx].valid <= 1'b0;
            end

            // taken branch empties the buffer
            if (flush) begin
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    mem[i].valid <= 1'b0;
                end
            end
        end
    end

    assign head_entry = mem[head_idx];

    // each completion must name an instruction already dispatched
    for (genvar p = 0; p < `ROB_CDB_PORTS; p++) begin : g_cdb_chk
        a_cdb_targets_valid: assert property (
            @(posedge clk) disable iff (rst)
            cdb[p].valid |-> mem[cdb[p].idx].valid
        );
    end

endmodule

`default_nettype wire

//--- rob_ptrs.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_settings.svh"

module rob_ptrs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  logic                  commit_fire,
    input  logic                  flush,
    output logic                  enq_fire,
    output logic [`ROB_IDX_W-1:0] tail_idx,
    output logic [`ROB_IDX_W-1:0] head_idx,
    output logic                  full,
    output logic                  empty
);

    // msb of each pointer is the wrap bit
    logic [`ROB_IDX_W:0] head_q;
    logic [`ROB_IDX_W:0] tail_q;
    logic [`ROB_IDX_W:0] head_nxt;
    logic [`ROB_IDX_W:0] count;

    assign head_idx = head_q[`ROB_IDX_W-1:0];
    assign tail_idx = tail_q[`ROB_IDX_W-1:0];

    // same slot, different lap means full
    assign full  = (head_q[`ROB_IDX_W] != tail_q[`ROB_IDX_W]) &&
                   (head_q[`ROB_IDX_W-1:0] == tail_q[`ROB_IDX_W-1:0]);
    assign empty = (head_q == tail_q);

    // a redirect cycle drops the incoming instruction
    assign enq_fire = dispatch_valid && !full && !flush;

    assign head_nxt = head_q + (`ROB_IDX_W+1)'(commit_fire);
    assign count    = tail_q - head_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_nxt;
            if (flush) begin
                // discard everything younger than the branch
                tail_q <= head_nxt;
            end else if (enq_fire) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // occupancy never exceeds the depth, so head stays behind tail
    a_head_not_past_tail: assert property (
        @(posedge clk) disable iff (rst)
        count <= (`ROB_IDX_W+1)'(`ROB_DEPTH)
    );

    // commit logic only sees a live head entry
    a_no_commit_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        commit_fire |-> !empty
    );

endmodule

`default_nettype wire

//--- rob_pkg.sv
`default_nettype none
`include "rob_settings.svh"

package rob_pkg;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } rv_opcode_e;

    typedef struct packed {
        logic [`PREG_W-1:0] preg;
        logic [`AREG_W-1:0] areg;
        logic [`XLEN-1:0]   pc;
        rv_opcode_e         opcode;
        logic               regf_we;
    } dispatch_t;

    typedef struct packed {
        logic                 valid;
        logic [`ROB_IDX_W-1:0] idx;
        logic [`XLEN-1:0]     result;
        logic                 br_taken;
        logic [`XLEN-1:0]     br_target;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        logic             done;
        dispatch_t        ins;
        logic [`XLEN-1:0] result;
        logic             br_taken;
        logic [`XLEN-1:0] br_target;
    } rob_entry_t;

    typedef struct packed {
        logic [`ORDER_W-1:0] order;
        logic [`PREG_W-1:0]  preg;
        logic [`AREG_W-1:0]  areg;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    result;
        logic                regf_we;
    } commit_t;

endpackage

`default_nettype wire

//--- rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// buffer geometry
`define ROB_DEPTH       16
`define ROB_IDX_W       4

// completion buses: alu, mul/div, branch/mem
`define ROB_CDB_PORTS   3

// datapath and register widths
`define XLEN            32
`define PREG_W          6
`define AREG_W          5

// retirement order counter
`define ORDER_W         64

`endif
